// ==== Makefile ====
TOP = SweepAcqTb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f compile.f

run: compile
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "^TESTS PASSED$$"

clean:
	rm -rf obj_dir

// ==== compile.f ====
hdl/SweepPkg.sv
hdl/AcqPkg.sv
hdl/SweepAcqFifo.sv
hdl/SweepAcqControl.sv
hdl/SweepAcqTop.sv
test/SweepAcqTb.sv

// ==== hdl/AcqPkg.sv ====
// Acquired data path types
package AcqPkg;

    // Parallel data word from the ASIC, same width on the output
    typedef logic [15:0] AcqWord;

    // FIFO fill count
    // 8 bits covers a depth of up to 128
    typedef logic [7:0] FifoLevel;

endpackage

// ==== hdl/SweepAcqControl.sv ====
`timescale 1ns/1ns

module SweepAcqControl (
    input  logic                  Clk,
    input  logic                  reset_n,
    input  logic                  StartPulse,
    input  logic                  DataTransmitDone,
    input  SweepPkg::DacCode      StartDAC0,
    input  SweepPkg::DacCode      EndDAC0,
    input  SweepPkg::PackageCount MaxPackageNumber,
    input  logic                  ParallelData_en,
    input  logic                  MicrorocConfigDone,
    input  AcqPkg::AcqWord        FifoData,
    output logic                  SingleACQStart,
    output logic                  ACQDone,
    output SweepPkg::DacCode      OutDAC0,
    output logic                  LoadSCParameter,
    output logic                  FifoRead,
    output logic                  FifoClear,
    output AcqPkg::AcqWord        SweepACQData,
    output logic                  SweepACQData_en
);

    SweepPkg::SweepState   state;
    // Current DAC code, drives OutDAC0
    SweepPkg::DacCode      curDac;
    // Strobes seen in this step
    SweepPkg::PackageCount pkgCount;
    // FIFO reads issued in this step
    SweepPkg::PackageCount readsIssued;
    // Read issued last cycle, FIFO data valid now
    logic                  readValid;

    //////////////////////////////
    // Sweep state machine
    //////////////////////////////

    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            state       <= SweepPkg::IDLE;
            curDac      <= '0;
            pkgCount    <= '0;
            readsIssued <= '0;
        end else begin
            case (state)
                SweepPkg::IDLE: begin
                    // Starts outside IDLE are ignored
                    if (StartPulse) begin
                        curDac <= StartDAC0;
                        // Empty range, straight to done
                        if (StartDAC0 > EndDAC0)
                            state <= SweepPkg::DONE;
                        else
                            state <= SweepPkg::LOAD;
                    end
                end
                SweepPkg::LOAD: begin
                    // Load pulse lasts this one cycle
                    state <= SweepPkg::WAITCFG;
                end
                SweepPkg::WAITCFG: begin
                    // Latency set by the slow-control shifter
                    if (MicrorocConfigDone)
                        state <= SweepPkg::ACQSTART;
                end
                SweepPkg::ACQSTART: begin
                    pkgCount    <= '0;
                    readsIssued <= '0;
                    state       <= SweepPkg::COLLECT;
                end
                SweepPkg::COLLECT: begin
                    // Limit reached, all words are in the FIFO by now
                    if (pkgCount == MaxPackageNumber)
                        state <= SweepPkg::HEADER;
                    else if (ParallelData_en)
                        pkgCount <= pkgCount + 1'b1;
                end
                SweepPkg::HEADER: begin
                    if (FifoRead)
                        readsIssued <= readsIssued + 1'b1;
                    state <= SweepPkg::DRAIN;
                end
                SweepPkg::DRAIN: begin
                    if (FifoRead)
                        readsIssued <= readsIssued + 1'b1;
                    // Last read already issued, its word shows this cycle
                    if (readsIssued == MaxPackageNumber)
                        state <= SweepPkg::WAITTX;
                end
                SweepPkg::WAITTX: begin
                    if (DataTransmitDone)
                        state <= SweepPkg::NEXT;
                end
                SweepPkg::NEXT: begin
                    // FIFO cleared here, then step the code
                    if (curDac == EndDAC0) begin
                        state <= SweepPkg::DONE;
                    end else begin
                        curDac <= curDac + 1'b1;
                        state  <= SweepPkg::LOAD;
                    end
                end
                SweepPkg::DONE: begin
                    state <= SweepPkg::IDLE;
                end
                default: begin
                    state <= SweepPkg::IDLE;
                end
            endcase
        end
    end

    //////////////////////////////
    // FIFO read tracking
    //////////////////////////////

    // Back-to-back reads from the header cycle on
    assign FifoRead = ((state == SweepPkg::HEADER) || (state == SweepPkg::DRAIN))
                      && (readsIssued != MaxPackageNumber);

    // FIFO read latency is one cycle
    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n)
            readValid <= 1'b0;
        else
            readValid <= FifoRead;
    end

    // Surplus words after each step
    // also stale strobes before this step's data
    assign FifoClear = (state == SweepPkg::NEXT) || (state == SweepPkg::ACQSTART);

    //////////////////////////////
    // Outputs
    //////////////////////////////

    assign LoadSCParameter = (state == SweepPkg::LOAD);
    assign SingleACQStart  = (state == SweepPkg::ACQSTART);
    assign ACQDone         = (state == SweepPkg::DONE);
    assign OutDAC0         = curDac;

    // Header first, then FIFO words as they come back
    assign SweepACQData    = (state == SweepPkg::HEADER) ? {SweepPkg::HeaderTag, curDac}
                                                         : FifoData;
    assign SweepACQData_en = (state == SweepPkg::HEADER) || readValid;

    // Loaded code stays inside the sweep range
    loadInRange: assert property (@(posedge Clk) disable iff (!reset_n)
        LoadSCParameter |-> (OutDAC0 <= EndDAC0))
        else $error("Load with code %0d above end %0d", OutDAC0, EndDAC0);

    // No output data while the ASIC is configuring
    quietInConfig: assert property (@(posedge Clk) disable iff (!reset_n)
        (state == SweepPkg::WAITCFG) |-> !SweepACQData_en)
        else $error("Output data during configuration");

endmodule

// ==== hdl/SweepAcqFifo.sv ====
`timescale 1ns/1ns

module SweepAcqFifo #(
    parameter int FifoDepth = 128
) (
    input  logic             Clk,
    input  logic             reset_n,
    input  logic             Clear,
    input  AcqPkg::AcqWord   WriteData,
    input  logic             Write,
    input  logic             Read,
    output AcqPkg::AcqWord   ReadData,
    output logic             Full,
    output logic             Empty,
    output AcqPkg::FifoLevel Level
);

    localparam int AddrWidth = $clog2(FifoDepth);

    AcqPkg::AcqWord         mem [FifoDepth];
    logic [AddrWidth-1:0]   wrPtr;
    logic [AddrWidth-1:0]   rdPtr;
    AcqPkg::FifoLevel       count;
    logic                   doWrite;
    logic                   doRead;

    // Depth must be a power of two, 128 at most
    initial begin
        assert (FifoDepth <= 128 && (FifoDepth & (FifoDepth - 1)) == 0)
            else $fatal(1, "Bad FIFO depth %0d", FifoDepth);
    end

    assign Full  = (count == AcqPkg::FifoLevel'(FifoDepth));
    assign Empty = (count == '0);
    assign Level = count;

    // Full drops writes, empty ignores reads
    assign doWrite = Write && !Full && !Clear;
    assign doRead  = Read && !Empty && !Clear;

    //////////////////////////////
    // Pointers and count
    //////////////////////////////

    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else if (Clear) begin
            // Empty in one cycle
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            // Pointers wrap on power-of-two depth
            if (doWrite)
                wrPtr <= wrPtr + 1'b1;
            if (doRead)
                rdPtr <= rdPtr + 1'b1;
            count <= count + AcqPkg::FifoLevel'(doWrite) - AcqPkg::FifoLevel'(doRead);
        end
    end

    //////////////////////////////
    // Storage, registered read
    //////////////////////////////

    always_ff @(posedge Clk) begin
        if (doWrite)
            mem[wrPtr] <= WriteData;
        // Word valid the cycle after Read
        if (doRead)
            ReadData <= mem[rdPtr];
    end

    noOverflow: assert property (@(posedge Clk) disable iff (!reset_n)
        !(Write && Full && !Clear))
        else $error("FIFO write while full, word dropped");

    noUnderflow: assert property (@(posedge Clk) disable iff (!reset_n)
        !(Read && Empty))
        else $error("FIFO read while empty");

endmodule

// ==== hdl/SweepAcqTop.sv ====
`timescale 1ns/1ns

module SweepAcqTop #(
    parameter int FifoDepth = 128
) (
    input  logic                  Clk,
    input  logic                  reset_n,
    // Sweep control
    input  logic                  SweepStart,
    output logic                  SingleACQStart,
    output logic                  ACQDone,
    input  logic                  DataTransmitDone,
    // Sweep parameters, held during a sweep
    input  SweepPkg::DacCode      StartDAC0,
    input  SweepPkg::DacCode      EndDAC0,
    input  SweepPkg::PackageCount MaxPackageNumber,
    // ASIC parallel data
    input  AcqPkg::AcqWord        ParallelData,
    input  logic                  ParallelData_en,
    // ASIC slow control
    output SweepPkg::DacCode      OutDAC0,
    output logic                  LoadSCParameter,
    input  logic                  MicrorocConfigDone,
    // Output stream to host
    output AcqPkg::AcqWord        SweepACQData,
    output logic                  SweepACQData_en
);

    //////////////////////////////
    // Start edge detector
    //////////////////////////////

    logic startSync1;
    logic startSync2;
    logic StartPulse;

    // Two sync flops, then a registered rising-edge pulse
    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            startSync1 <= 1'b0;
            startSync2 <= 1'b0;
            StartPulse <= 1'b0;
        end else begin
            startSync1 <= SweepStart;
            startSync2 <= startSync1;
            // One pulse per rising level, held level gives nothing more
            StartPulse <= startSync1 & ~startSync2;
        end
    end

    //////////////////////////////
    // Controller and data FIFO
    //////////////////////////////

    logic                 FifoRead;
    logic                 FifoClear;
    AcqPkg::AcqWord       FifoData;
    AcqPkg::FifoLevel     fifoLevel;

    SweepAcqControl uControl (
        .Clk                (Clk),
        .reset_n            (reset_n),
        .StartPulse         (StartPulse),
        .DataTransmitDone   (DataTransmitDone),
        .StartDAC0          (StartDAC0),
        .EndDAC0            (EndDAC0),
        .MaxPackageNumber   (MaxPackageNumber),
        .ParallelData_en    (ParallelData_en),
        .MicrorocConfigDone (MicrorocConfigDone),
        .FifoData           (FifoData),
        .SingleACQStart     (SingleACQStart),
        .ACQDone            (ACQDone),
        .OutDAC0            (OutDAC0),
        .LoadSCParameter    (LoadSCParameter),
        .FifoRead           (FifoRead),
        .FifoClear          (FifoClear),
        .SweepACQData       (SweepACQData),
        .SweepACQData_en    (SweepACQData_en)
    );

    // Write side straight from the ASIC strobe
    // Clear pulse from the controller drops surplus words
    SweepAcqFifo #(
        .FifoDepth (FifoDepth)
    ) uFifo (
        .Clk       (Clk),
        .reset_n   (reset_n),
        .Clear     (FifoClear),
        .WriteData (ParallelData),
        .Write     (ParallelData_en),
        .Read      (FifoRead),
        .ReadData  (FifoData),
        .Full      (),
        .Empty     (),
        .Level     (fifoLevel)
    );

    // Package limit must fit in the FIFO
    packageFits: assert property (@(posedge Clk) disable iff (!reset_n)
        StartPulse |-> (MaxPackageNumber <= FifoDepth))
        else $error("MaxPackageNumber %0d exceeds FIFO depth", MaxPackageNumber);

    // Whole package buffered when the header goes out
    packageBuffered: assert property (@(posedge Clk) disable iff (!reset_n)
        $rose(SweepACQData_en) |-> (16'(fifoLevel) >= MaxPackageNumber))
        else $error("FIFO holds %0d words at header", fifoLevel);

endmodule

// ==== hdl/SweepPkg.sv ====
// Sweep-level types and constants
package SweepPkg;

    // Threshold DAC code of the readout ASIC
    typedef logic [9:0] DacCode;

    // Data words collected per DAC step
    typedef logic [15:0] PackageCount;

    // Tag in the upper bits of each step header
    // Header word is {HeaderTag, DacCode}
    localparam logic [5:0] HeaderTag = 6'b101010;

    // Controller states, in sweep order
    typedef enum logic [3:0] {
        IDLE, LOAD, WAITCFG, ACQSTART, COLLECT,
        HEADER, DRAIN, WAITTX, NEXT, DONE
    } SweepState;

endpackage

// ==== test/SweepAcqTb.sv ====
`timescale 1ns/1ns

module SweepAcqTb;

    localparam int TimeoutCycles = 2000;
    localparam int LoadEvent  = 0;
    localparam int AcqEvent   = 1;
    localparam int BurstEvent = 2;
    localparam int DoneEvent  = 3;

    logic                  Clk;
    logic                  reset_n;
    logic                  SweepStart;
    logic                  DataTransmitDone;
    SweepPkg::DacCode      StartDAC0;
    SweepPkg::DacCode      EndDAC0;
    SweepPkg::PackageCount MaxPackageNumber;
    AcqPkg::AcqWord        ParallelData;
    logic                  ParallelData_en;
    logic                  MicrorocConfigDone;
    logic                  SingleACQStart;
    logic                  ACQDone;
    SweepPkg::DacCode      OutDAC0;
    logic                  LoadSCParameter;
    AcqPkg::AcqWord        SweepACQData;
    logic                  SweepACQData_en;

    // Current test line
    string  testName;
    int     startCode;
    int     endCode;
    int     pkgNum;
    int     extraNum;
    int     resetFlag;
    int     stepCount;
    // Run bookkeeping
    int     errorCount;
    int     testsRun;
    bit     timedOut;
    integer seed;
    // Monitor counters, rising edge only
    int     loadCount;
    int     acqCount;
    int     doneCount;
    int     burstCount;
    int     burstLen;
    bit     inBurst;
    bit     cfgPending;
    // Counted words in send order
    AcqPkg::AcqWord expWords[$];

    SweepAcqTop #(
        .FifoDepth (128)
    ) dut_i (
        .Clk                (Clk),
        .reset_n            (reset_n),
        .SweepStart         (SweepStart),
        .SingleACQStart     (SingleACQStart),
        .ACQDone            (ACQDone),
        .DataTransmitDone   (DataTransmitDone),
        .StartDAC0          (StartDAC0),
        .EndDAC0            (EndDAC0),
        .MaxPackageNumber   (MaxPackageNumber),
        .ParallelData       (ParallelData),
        .ParallelData_en    (ParallelData_en),
        .OutDAC0            (OutDAC0),
        .LoadSCParameter    (LoadSCParameter),
        .MicrorocConfigDone (MicrorocConfigDone),
        .SweepACQData       (SweepACQData),
        .SweepACQData_en    (SweepACQData_en)
    );

    initial begin
        Clk = 1'b0;
        forever #10 Clk = ~Clk;
    end

    task automatic reportMismatch(input string what, input int expected, input int actual);
        errorCount++;
        $display("** Error %s: %s expected 0x%0h, actual 0x%0h",
                 testName, what, expected, actual);
    endtask

    task automatic reportProblem(input string what);
        errorCount++;
        $display("Test %s failed: %s", testName, what);
    endtask

    //////////////////////////////
    // Output monitor
    //////////////////////////////

    // Samples on the rising edge, inputs change on the falling edge
    always @(posedge Clk) begin
        AcqPkg::AcqWord expWord;
        if (reset_n) begin
            // Codes run upward from the start code
            if (LoadSCParameter) begin
                if (loadCount >= stepCount)
                    reportProblem("load pulse after the last step");
                else if (OutDAC0 !== SweepPkg::DacCode'(startCode + loadCount))
                    reportMismatch("OutDAC0 at load", startCode + loadCount, int'(OutDAC0));
                loadCount++;
            end
            if (SingleACQStart) begin
                if (!cfgPending)
                    reportProblem("SingleACQStart without MicrorocConfigDone");
                cfgPending = 1'b0;
                acqCount++;
            end
            if (ACQDone) begin
                if (burstCount != stepCount)
                    reportMismatch("bursts before ACQDone", stepCount, burstCount);
                doneCount++;
            end
            if (SweepACQData_en) begin
                if (!inBurst) begin
                    // Header is tag above the code of this step
                    expWord = {SweepPkg::HeaderTag, SweepPkg::DacCode'(startCode + burstCount)};
                    if (SweepACQData !== expWord)
                        reportMismatch("header word", int'(expWord), int'(SweepACQData));
                    inBurst  = 1'b1;
                    burstLen = 1;
                end else begin
                    burstLen++;
                    if (expWords.size() == 0) begin
                        reportProblem("output word with no data word left to expect");
                    end else begin
                        expWord = expWords.pop_front();
                        if (SweepACQData !== expWord)
                            reportMismatch("data word", int'(expWord), int'(SweepACQData));
                    end
                end
            end else if (inBurst) begin
                // End of run, length and leftovers
                inBurst = 1'b0;
                if (burstLen != pkgNum + 1)
                    reportMismatch("burst length", pkgNum + 1, burstLen);
                if (expWords.size() != 0)
                    reportMismatch("words missing from burst", 0, expWords.size());
                burstCount++;
            end
        end
    end

    function automatic int eventCount(input int kind);
        case (kind)
            LoadEvent:  return loadCount;
            AcqEvent:   return acqCount;
            BurstEvent: return burstCount;
            default:    return doneCount;
        endcase
    endfunction

    // Poll a monitor counter on falling edges
    task automatic waitForCount(input int kind, input int target, input string what);
        int                  cycles;
        SweepPkg::SweepState st;
        cycles = 0;
        while (eventCount(kind) < target && !timedOut) begin
            @(negedge Clk);
            cycles++;
            if (cycles > TimeoutCycles) begin
                st = dut_i.uControl.state;
                $display("Timeout in test %s: no %s within %0d cycles, controller in %s",
                         testName, what, TimeoutCycles, st.name());
                errorCount++;
                timedOut = 1'b1;
            end
        end
    endtask

    //////////////////////////////
    // ASIC and host models
    //////////////////////////////

    // Counted words go to the expected queue, extras do not
    task automatic sendWords(input int counted, input int extra);
        int             gap;
        AcqPkg::AcqWord word;
        for (int i = 0; i < counted + extra; i++) begin
            gap = int'($unsigned($random(seed)) % 3);
            if (gap != 0) begin
                ParallelData_en = 1'b0;
                repeat (gap) @(negedge Clk);
            end
            word = AcqPkg::AcqWord'($random(seed));
            ParallelData    = word;
            ParallelData_en = 1'b1;
            if (i < counted)
                expWords.push_back(word);
            @(negedge Clk);
        end
        ParallelData_en = 1'b0;
    endtask

    task automatic checkQuiet(input string when);
        if (LoadSCParameter !== 1'b0)
            reportMismatch({"LoadSCParameter ", when}, 0, int'(LoadSCParameter));
        if (SingleACQStart !== 1'b0)
            reportMismatch({"SingleACQStart ", when}, 0, int'(SingleACQStart));
        if (ACQDone !== 1'b0)
            reportMismatch({"ACQDone ", when}, 0, int'(ACQDone));
        if (SweepACQData_en !== 1'b0)
            reportMismatch({"SweepACQData_en ", when}, 0, int'(SweepACQData_en));
        if (OutDAC0 !== '0)
            reportMismatch({"OutDAC0 ", when}, 0, int'(OutDAC0));
    endtask

    // Reset in the middle of a collect phase
    task automatic midRunReset();
        reset_n            = 1'b0;
        SweepStart         = 1'b0;
        MicrorocConfigDone = 1'b0;
        DataTransmitDone   = 1'b0;
        repeat (4) begin
            @(negedge Clk);
            checkQuiet("during reset");
        end
        reset_n    = 1'b1;
        inBurst    = 1'b0;
        cfgPending = 1'b0;
        expWords.delete();
        @(negedge Clk);
        checkQuiet("after reset");
    endtask

    task automatic runTest();
        int delay;
        stepCount  = (startCode > endCode) ? 0 : endCode - startCode + 1;
        loadCount  = 0;
        acqCount   = 0;
        doneCount  = 0;
        burstCount = 0;
        inBurst    = 1'b0;
        cfgPending = 1'b0;
        expWords.delete();
        StartDAC0        = SweepPkg::DacCode'(startCode);
        EndDAC0          = SweepPkg::DacCode'(endCode);
        MaxPackageNumber = SweepPkg::PackageCount'(pkgNum);
        SweepStart       = 1'b1;
        for (int step = 0; step < stepCount; step++) begin
            waitForCount(LoadEvent, step + 1, "LoadSCParameter");
            if (timedOut)
                return;
            // Slow-control shifter latency
            delay = 1 + int'($unsigned($random(seed)) % 8);
            repeat (delay) @(negedge Clk);
            MicrorocConfigDone = 1'b1;
            cfgPending         = 1'b1;
            @(negedge Clk);
            MicrorocConfigDone = 1'b0;
            waitForCount(AcqEvent, step + 1, "SingleACQStart");
            if (timedOut)
                return;
            if (resetFlag != 0) begin
                sendWords(2, 0);
                midRunReset();
                return;
            end
            sendWords(pkgNum, extraNum);
            waitForCount(BurstEvent, step + 1, "output burst");
            if (timedOut)
                return;
            // Host transfer time
            delay = 2 + int'($unsigned($random(seed)) % 3);
            repeat (delay) @(negedge Clk);
            DataTransmitDone = 1'b1;
            @(negedge Clk);
            DataTransmitDone = 1'b0;
        end
        waitForCount(DoneEvent, 1, "ACQDone");
        if (timedOut)
            return;
        // Start level still high, a second sweep would load again
        repeat (30) @(negedge Clk);
        if (loadCount != stepCount)
            reportMismatch("load pulses", stepCount, loadCount);
        if (acqCount != stepCount)
            reportMismatch("SingleACQStart pulses", stepCount, acqCount);
        if (doneCount != 1)
            reportMismatch("ACQDone pulses", 1, doneCount);
        SweepStart = 1'b0;
        repeat (4) @(negedge Clk);
    endtask

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial begin
        int    fd;
        int    code;
        int    fields;
        string line;
        seed       = 91568;
        errorCount = 0;
        testsRun   = 0;
        timedOut   = 1'b0;
        stepCount  = 0;
        startCode  = 0;
        pkgNum     = 0;
        testName   = "init";
        reset_n            = 1'b0;
        SweepStart         = 1'b0;
        DataTransmitDone   = 1'b0;
        StartDAC0          = '0;
        EndDAC0            = '0;
        MaxPackageNumber   = '0;
        ParallelData       = '0;
        ParallelData_en    = 1'b0;
        MicrorocConfigDone = 1'b0;
        repeat (8) @(negedge Clk);
        reset_n = 1'b1;
        @(negedge Clk);
        fd = $fopen("test/sweepTests.txt", "r");
        if (fd == 0) begin
            reportProblem("cannot open test/sweepTests.txt");
        end else begin
            while (!$feof(fd) && !timedOut) begin
                code = $fgets(line, fd);
                // Skip comments and blank lines
                if (code != 0 && line.len() > 1 && line[0] != "#") begin
                    fields = $sscanf(line, "%s %d %d %d %d %d", testName, startCode,
                                     endCode, pkgNum, extraNum, resetFlag);
                    if (fields == 6) begin
                        testsRun++;
                        runTest();
                    end else begin
                        reportProblem("malformed line in the test file");
                    end
                end
            end
            $fclose(fd);
        end
        $display("Tests run: %0d, errors: %0d", testsRun, errorCount);
        if (errorCount == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

// ==== test/sweepTests.txt ====
# name start_code end_code packages extra_strobes reset_mid_run
# decimal columns, reset_mid_run is 0 or 1
basic 10 12 4 0 0
single 100 100 8 0 0
extras 5 8 6 3 0
oneWord 0 2 1 2 0
empty 20 19 4 0 0
headerOnly 300 301 0 2 0
fullFifo 1020 1023 128 0 0
nearFull 50 51 120 8 0
resetRun 7 10 5 0 1
afterReset 7 8 3 1 0
wideRange 200 215 2 1 0
